// File: sources.f
+incdir+dv
hw/afu_pkg.sv
hw/cu_cmd_if.sv
hw/wed_dispatch.sv
hw/cu_control.sv
hw/write_arbiter.sv
hw/afu_top.sv
dv/afu_tb.sv

// File: dv/afu_tb_cases.svh
`ifndef AFU_TB_CASES_SVH
`define AFU_TB_CASES_SVH

// Each entry is one job with a name, a WED address, a cu_enable mask, a write_buffer_full
// pattern (bit k holds the buffer full in cycle k of the job) and a flag for a second WED
// sent while busy.
localparam int num_cases = 8;

string             case_name [num_cases];
logic [addr_w-1:0] case_addr [num_cases];
logic [n_cu-1:0]   case_mask [num_cases];
logic [31:0]       case_full [num_cases];
logic              case_busy_wed [num_cases];

task automatic add_case(input int idx, input string name, input logic [addr_w-1:0] addr,
                        input logic [n_cu-1:0] mask, input logic [31:0] full,
                        input logic busy_wed);
  case_name[idx]     = name;
  case_addr[idx]     = addr;
  case_mask[idx]     = mask;
  case_full[idx]     = full;
  case_busy_wed[idx] = busy_wed;
endtask

// The last entry makes the unit offsets carry into bit 47.
task automatic load_cases();
  add_case(0, "all_units",      64'h0000_0010_0000_0000, 4'b1111, 32'h0000_0000, 1'b0);
  add_case(1, "unit_0_only",    64'h0000_0020_0000_1000, 4'b0001, 32'h0000_0000, 1'b0);
  add_case(2, "odd_units",      64'h0000_0030_0000_2000, 4'b1010, 32'h0000_0000, 1'b0);
  add_case(3, "no_units",       64'h0000_0040_0000_3000, 4'b0000, 32'h0000_0000, 1'b0);
  add_case(4, "full_stretch",   64'h0000_0050_0000_4000, 4'b1111, 32'h0000_3FF0, 1'b0);
  add_case(5, "full_toggle",    64'h0000_0060_0000_5000, 4'b1101, 32'h0000_AAA8, 1'b0);
  add_case(6, "wed_while_busy", 64'h0000_0070_0000_6000, 4'b1111, 32'h0000_0F00, 1'b1);
  add_case(7, "carry_address",  64'h0000_7FFF_FFFF_FF80, 4'b0110, 32'h0000_0000, 1'b0);
endtask

`endif

// File: dv/afu_tb.sv
`timescale 1ns/1ps

module afu_tb
  import afu_pkg::*;
();

  localparam int reset_cycles = 10;
  localparam int job_limit    = 48;

  logic                    clock;
  logic                    rstn;
  logic                    wed_valid;
  logic [addr_w-1:0]       wed_address;
  logic [n_cu-1:0]         cu_enable;
  logic                    write_buffer_full;
  logic                    write_command_valid;
  cmd_code_t               write_command_code;
  logic [addr_w-1:0]       write_command_address;
  logic [write_size_w-1:0] write_command_size;
  logic [cu_id_w-1:0]      write_command_cu_id;
  cmd_type_t               write_command_type;
  logic [data_w-1:0]       write_data_0;
  logic [data_w-1:0]       write_data_1;
  logic                    job_done;

  `include "afu_tb_cases.svh"

  // Each job with its gap fits well inside 64 cycles.
  localparam int cycle_limit = num_cases * 64 + reset_cycles;

  string             cur_name;
  logic [addr_w-1:0] cur_addr;
  logic [addr_w-1:0] ignored_addr;
  logic [n_cu-1:0]   cur_mask;
  logic              cur_busy_wed;
  logic [n_cu-1:0]   seen;
  logic              full_prev;
  logic              job_finished;
  int                done_count;
  int                test_errors;
  int                pass_count;
  int                fail_count;
  int                cycle_count;
  integer            seed;

  afu_top UUT (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic check_value(input string field, input logic [data_w-1:0] expected,
                             input logic [data_w-1:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s: %s expected %0h, got %0h", cur_name, field, expected, actual);
      test_errors++;
    end
  endtask

  // Host software polls for the marker in byte 44 and finds the unit id in the next byte.
  function automatic logic [data_w-1:0] expected_line(input int unsigned id);
    logic [data_w-1:0] line;
    line = '0;
    line[44*8 +: 8] = 8'h02;
    line[cu_id_byte*8 +: 8] = id[7:0];
    return line;
  endfunction

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("%s: ok", cur_name);
      pass_count++;
    end else begin
      $display("%s: %0d errors", cur_name, test_errors);
      fail_count++;
    end
    test_errors = 0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Host port monitor
  // ~~~~~~~~~~~~~~~~~~~~

  always @(negedge clock) begin
    int unsigned id;
    logic [addr_w-1:0] exp_addr;
    if (rstn) begin
      if (full_prev && write_command_valid) begin
        $display("Error in %s: a write left in the cycle after the buffer was full", cur_name);
        test_errors++;
      end
      full_prev = write_buffer_full;
      if (job_done) begin
        job_finished = 1'b1;
        done_count++;
      end
      if (write_command_valid) begin
        id = write_command_cu_id;
        exp_addr = cur_addr + 64'd128 + 64'(id * 128);
        if (id >= n_cu || !cur_mask[id]) begin
          $display("Error in %s: write for unit %0d, which is not enabled", cur_name, id);
          test_errors++;
        end else if (seen[id]) begin
          $display("Error in %s: unit %0d was written twice", cur_name, id);
          test_errors++;
        end else begin
          seen[id] = 1'b1;
          check_value("write_command_address", exp_addr, write_command_address);
          check_value("write_command_code", cmd_write_ms, write_command_code);
          check_value("write_command_size", 1, write_command_size);
          check_value("write_command_type", cmd_type_write, write_command_type);
          check_value("write_data_0", expected_line(id), write_data_0);
          check_value("write_data_1", expected_line(id), write_data_1);
        end
        for (int k = 0; k < n_cu; k++) begin
          exp_addr = ignored_addr + 64'd128 + 64'(k * 128);
          if (cur_busy_wed && write_command_address == exp_addr) begin
            $display("Error in %s: a write used the address of the ignored WED", cur_name);
            test_errors++;
          end
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Job sequence
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic run_job(input int t);
    int cyc;
    @(posedge clock);
    cur_name     = case_name[t];
    cur_addr     = case_addr[t];
    cur_mask     = case_mask[t];
    cur_busy_wed = case_busy_wed[t];
    ignored_addr = case_addr[t] ^ 64'h0000_0000_0010_0000;
    seen         = '0;
    done_count   = 0;
    job_finished = 1'b0;
    wed_valid         <= 1'b1;
    wed_address       <= case_addr[t];
    cu_enable         <= case_mask[t];
    write_buffer_full <= case_full[t][0];
    cyc = 0;
    while (!job_finished && cyc < job_limit) begin
      @(posedge clock);
      cyc++;
      wed_valid <= cur_busy_wed && cyc == 2;
      if (cur_busy_wed && cyc == 2) begin
        wed_address <= ignored_addr;
      end
      write_buffer_full <= (cyc < 32) ? case_full[t][cyc] : 1'b0;
    end
    write_buffer_full <= 1'b0;
    if (!job_finished) begin
      $display("Error in %s: job_done did not arrive within %0d cycles", cur_name, job_limit);
      test_errors++;
    end
    repeat (2) @(posedge clock);
    check_value("units_written", cur_mask, seen);
    check_value("job_done_count", 1, done_count);
    finish_test();
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: the run did not end within %0d cycles", cycle_limit);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int gap;
    rstn              = 1'b0;
    wed_valid         = 1'b0;
    wed_address       = '0;
    cu_enable         = '0;
    write_buffer_full = 1'b0;
    seed         = 33066;
    full_prev    = 1'b0;
    seen         = '0;
    cur_mask     = '0;
    cur_addr     = '0;
    ignored_addr = '0;
    cur_busy_wed = 1'b0;
    job_finished = 1'b0;
    done_count   = 0;
    test_errors  = 0;
    pass_count   = 0;
    fail_count   = 0;
    cur_name     = "idle_after_reset";
    load_cases();
    repeat (reset_cycles) @(posedge clock);
    rstn <= 1'b1;
    repeat (8) begin
      @(negedge clock);
      check_value("write_command_valid", 0, write_command_valid);
      check_value("job_done", 0, job_done);
    end
    finish_test();
    for (int t = 0; t < num_cases; t++) begin
      run_job(t);
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clock);
    end
    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && test_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: hw/afu_top.sv
`timescale 1ns/1ps

module afu_top
  import afu_pkg::*;
(
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    wed_valid,
  input  logic [addr_w-1:0]       wed_address,
  input  logic [n_cu-1:0]         cu_enable,
  input  logic                    write_buffer_full,
  output logic                    write_command_valid,
  output cmd_code_t               write_command_code,
  output logic [addr_w-1:0]       write_command_address,
  output logic [write_size_w-1:0] write_command_size,
  output logic [cu_id_w-1:0]      write_command_cu_id,
  output cmd_type_t               write_command_type,
  output logic [data_w-1:0]       write_data_0,
  output logic [data_w-1:0]       write_data_1,
  output logic                    job_done
);

  logic              job_start;
  logic [addr_w-1:0] base_address;
  logic [n_cu-1:0]   served;

  cu_cmd_if cu_cmds [n_cu] ();

  wed_dispatch u_dispatch (
    .clock        (clock),
    .rstn         (rstn),
    .wed_valid    (wed_valid),
    .wed_address  (wed_address),
    .cu_enable    (cu_enable),
    .served       (served),
    .job_start    (job_start),
    .base_address (base_address),
    .job_done     (job_done)
  );

  // One controller per compute unit.
  for (genvar i = 0; i < n_cu; i++) begin : g_cu
    cu_control #(
      .cu_index (i)
    ) u_cu (
      .clock        (clock),
      .rstn         (rstn),
      .enabled      (cu_enable[i]),
      .job_start    (job_start),
      .base_address (base_address),
      .cmd          (cu_cmds[i])
    );
  end

  write_arbiter u_arbiter (
    .clock                 (clock),
    .rstn                  (rstn),
    .write_buffer_full     (write_buffer_full),
    .cmds                  (cu_cmds),
    .write_command_valid   (write_command_valid),
    .write_command_code    (write_command_code),
    .write_command_address (write_command_address),
    .write_command_size    (write_command_size),
    .write_command_cu_id   (write_command_cu_id),
    .write_command_type    (write_command_type),
    .write_data_0          (write_data_0),
    .write_data_1          (write_data_1),
    .served                (served)
  );

endmodule

// File: hw/write_arbiter.sv
`timescale 1ns/1ps

module write_arbiter
  import afu_pkg::*;
(
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    write_buffer_full,
  cu_cmd_if.arb                   cmds [n_cu],
  output logic                    write_command_valid,
  output cmd_code_t               write_command_code,
  output logic [addr_w-1:0]       write_command_address,
  output logic [write_size_w-1:0] write_command_size,
  output logic [cu_id_w-1:0]      write_command_cu_id,
  output cmd_type_t               write_command_type,
  output logic [data_w-1:0]       write_data_0,
  output logic [data_w-1:0]       write_data_1,
  output logic [n_cu-1:0]         served
);

  logic [n_cu-1:0]     req_vec;
  logic [n_cu-1:0]     pending;
  logic [addr_w-1:0]   slot_addr [n_cu];
  logic [data_w-1:0]   slot_data_0 [n_cu];
  logic [data_w-1:0]   slot_data_1 [n_cu];
  logic [cu_idx_w-1:0] rr_ptr;
  logic [cu_idx_w-1:0] win_idx;
  logic                found;
  logic                grant;
  logic [n_cu-1:0]     grant_vec;

  // ~~~~~~~~~~~~~~~~~~~~
  // Pending slots
  // ~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < n_cu; i++) begin : g_slot
    assign req_vec[i] = cmds[i].req;

    always_ff @(posedge clock) begin
      if (cmds[i].req) begin
        slot_addr[i]   <= cmds[i].address;
        slot_data_0[i] <= cmds[i].data_0;
        slot_data_1[i] <= cmds[i].data_1;
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      pending <= '0;
    end else begin
      pending <= (pending | req_vec) & ~grant_vec;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Round-robin pick
  // ~~~~~~~~~~~~~~~~~~~~

  // Search starts at the pointer, which sits just past the last winner.
  always_comb begin
    int unsigned cand;
    found   = 1'b0;
    win_idx = '0;
    for (int unsigned k = 0; k < n_cu; k++) begin
      cand = (int'(rr_ptr) + k) % n_cu;
      if (!found && pending[cand]) begin
        found   = 1'b1;
        win_idx = cu_idx_w'(cand);
      end
    end
  end

  assign grant     = found && !write_buffer_full;
  assign grant_vec = grant ? (n_cu'(1) << win_idx) : '0;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rr_ptr <= '0;
    end else if (grant) begin
      rr_ptr <= cu_idx_w'((int'(win_idx) + 1) % n_cu);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Host port
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      write_command_valid   <= 1'b0;
      write_command_code    <= cmd_invalid;
      write_command_address <= '0;
      write_command_size    <= '0;
      write_command_cu_id   <= '0;
      write_command_type    <= cmd_type_invalid;
      write_data_0          <= '0;
      write_data_1          <= '0;
      served                <= '0;
    end else begin
      write_command_valid   <= grant;
      write_command_code    <= grant ? cmd_write_ms : cmd_invalid;
      write_command_address <= grant ? slot_addr[win_idx] : '0;
      write_command_size    <= grant ? write_size : '0;
      write_command_cu_id   <= grant ? cu_id_w'(win_idx) : '0;
      write_command_type    <= grant ? cmd_type_write : cmd_type_invalid;
      write_data_0          <= grant ? slot_data_0[win_idx] : '0;
      write_data_1          <= grant ? slot_data_1[win_idx] : '0;
      served                <= grant_vec;
    end
  end

  // Each unit requests at most once per job.
  a_no_slot_overwrite : assert property (
    @(posedge clock) disable iff (!rstn) (req_vec & pending) == '0
  );

  // The host buffer being full must hold every command back.
  a_no_write_after_full : assert property (
    @(posedge clock) disable iff (!rstn) write_buffer_full |=> !write_command_valid
  );

endmodule

// File: hw/cu_control.sv
`timescale 1ns/1ps

module cu_control
  import afu_pkg::*;
#(
  parameter int unsigned cu_index = 0
) (
  input  logic              clock,
  input  logic              rstn,
  input  logic              enabled,
  input  logic              job_start,
  input  logic [addr_w-1:0] base_address,
  cu_cmd_if.cu              cmd
);

  logic [addr_w-1:0] line_offset;
  logic [cu_id_w-1:0] unit_id;
  logic [data_w-1:0] status_line;

  // Each unit writes its own line in the status area.
  assign line_offset = addr_w'(status_offset + cu_index * line_bytes);
  assign unit_id     = cu_id_w'(cu_index);

  // ~~~~~~~~~~~~~~~~~~~~
  // Status payload
  // ~~~~~~~~~~~~~~~~~~~~

  // Both halves report the same thing, so the host can poll either one.
  always_comb begin
    status_line = '0;
    status_line[done_marker_byte*8 +: 8]  = done_marker;
    status_line[cu_id_byte*8 +: cu_id_w]  = unit_id;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Command build
  // ~~~~~~~~~~~~~~~~~~~~

  // A single strobe per job, since job_start is itself a single strobe.
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd.req <= 1'b0;
    end else begin
      cmd.req <= job_start && enabled;
    end
  end

  // Fields are set with req and held until the next job of this unit.
  always_ff @(posedge clock) begin
    if (job_start && enabled) begin
      cmd.address <= base_address + line_offset;
      cmd.data_0  <= status_line;
      cmd.data_1  <= status_line;
    end
  end

  // The arbiter has one slot per unit, so a second back-to-back req would overwrite it.
  a_req_single : assert property (
    @(posedge clock) disable iff (!rstn) cmd.req |=> !cmd.req
  );

endmodule

// File: hw/wed_dispatch.sv
`timescale 1ns/1ps

module wed_dispatch
  import afu_pkg::*;
(
  input  logic              clock,
  input  logic              rstn,
  input  logic              wed_valid,
  input  logic [addr_w-1:0] wed_address,
  input  logic [n_cu-1:0]   cu_enable,
  input  logic [n_cu-1:0]   served,
  output logic              job_start,
  output logic [addr_w-1:0] base_address,
  output logic              job_done
);

  logic            busy;
  logic [n_cu-1:0] en_mask;
  logic [n_cu-1:0] done_mask;
  logic            all_served;

  // Counts the strobes of this cycle too, so job_done comes one cycle after the last write.
  assign all_served = ((done_mask | served) & en_mask) == en_mask;

  // ~~~~~~~~~~~~~~~~~~~~
  // Idle / busy FSM
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      busy      <= 1'b0;
      job_start <= 1'b0;
      job_done  <= 1'b0;
      en_mask   <= '0;
      done_mask <= '0;
    end else begin
      job_start <= 1'b0;
      job_done  <= 1'b0;
      if (!busy) begin
        // A new WED is only taken while idle.
        if (wed_valid) begin
          busy      <= 1'b1;
          job_start <= 1'b1;
          en_mask   <= cu_enable;
          done_mask <= '0;
        end
      end else if (all_served) begin
        busy      <= 1'b0;
        job_done  <= 1'b1;
        done_mask <= '0;
      end else begin
        done_mask <= done_mask | served;
      end
    end
  end

  // The base is held for the whole job.
  always_ff @(posedge clock) begin
    if (!busy && wed_valid) begin
      base_address <= wed_address;
    end
  end

  // The arbiter may only serve units that this job started.
  a_served_in_mask : assert property (
    @(posedge clock) disable iff (!rstn) (served & ~en_mask) == '0
  );

endmodule

// File: hw/cu_cmd_if.sv
`timescale 1ns/1ps

interface cu_cmd_if
  import afu_pkg::*;
();

  // One-cycle strobe, raised once per job by the unit.
  logic req;

  // Held by the unit from req until the next job.
  logic [addr_w-1:0] address;
  logic [data_w-1:0] data_0;
  logic [data_w-1:0] data_1;

  // Compute unit side.
  modport cu (
    output req,
    output address,
    output data_0,
    output data_1
  );

  // The arbiter only samples and drives nothing back.
  modport arb (
    input req,
    input address,
    input data_0,
    input data_1
  );

endinterface

// File: hw/afu_pkg.sv
package afu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Sizes
  // ~~~~~~~~~~~~~~~~~~~~

  // Number of compute units served by one WED.
  localparam int unsigned n_cu = 4;

  localparam int unsigned cu_idx_w = (n_cu > 1) ? $clog2(n_cu) : 1;

  localparam int unsigned addr_w = 64;

  // Each status write moves two halves of a 1024-bit cache line.
  localparam int unsigned data_w = 512;

  localparam int unsigned cu_id_w = 8;

  localparam int unsigned write_size_w = 12;

  // ~~~~~~~~~~~~~~~~~~~~
  // Host command encoding
  // ~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [12:0] {
    cmd_invalid  = 13'h0000,
    cmd_write_ms = 13'h0D70
  } cmd_code_t;

  // Internal tag carried next to the host command, as the unit sees it.
  typedef enum logic [1:0] {
    cmd_type_invalid = 2'd0,
    cmd_type_read    = 2'd1,
    cmd_type_write   = 2'd2
  } cmd_type_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Status area layout
  // ~~~~~~~~~~~~~~~~~~~~

  // The status area starts one line above the WED base.
  localparam int unsigned status_offset = 128;

  // Each unit owns a full line inside the status area.
  localparam int unsigned line_bytes = 128;

  // Transfer size of one status write.
  localparam logic [write_size_w-1:0] write_size = 12'h001;

  // Completion marker, as polled by host software.
  localparam logic [7:0] done_marker = 8'h02;

  localparam int unsigned done_marker_byte = 44;

  // The writing unit puts its id right after the marker.
  localparam int unsigned cu_id_byte = 45;

endpackage
